// ==== logic/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int WORD_W = 16;
    localparam int VADDR_W = 16;
    localparam int PADDR_W = 24;
    localparam int SEL_W = 2;

    // paging splits the virtual address into page number and offset
    localparam int PAGE_OFS_W = 12;
    localparam int PPAGE_W = PADDR_W - PAGE_OFS_W;
    localparam int PAGE_ENTRIES = 16;

    // words per icache line as fixed by the burst8 fill
    localparam int LINE_WORDS = 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [VADDR_W-1:0] vaddr_t;
    typedef logic [PADDR_W-1:0] paddr_t;
    typedef logic [PPAGE_W-1:0] ppage_t;
    typedef logic [SEL_W-1:0] sel_t;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        paddr_t adr;
        word_t dat;
        sel_t sel;
        logic burst8;
    } wb_req_t;

    typedef struct packed {
        logic ack;
        logic err;
        word_t dat;
    } wb_rsp_t;

    typedef struct packed {
        logic we;
        word_t addr;
        word_t data;
    } sr_write_t;

endpackage

`default_nettype wire

// ==== logic/page_translator.sv ====
`timescale 1ns/1ps
`default_nettype none

module page_translator
    import mem_pkg::*;
#(
    parameter word_t SR_BASE = 16'h0100
) (
    input wire i_clk,
    input wire i_rst,

    input wire sr_write_t i_sr,

    input wire i_page_en,
    input wire vaddr_t i_vaddr,
    output paddr_t o_paddr
);

    localparam int IDX_W = $clog2(PAGE_ENTRIES);

    ppage_t page_table [PAGE_ENTRIES];

    word_t sr_ofs;
    logic sr_hit;
    logic [IDX_W-1:0] sr_idx;
    logic [IDX_W-1:0] vpage;

    // window check relative to this translator's base
    assign sr_ofs = i_sr.addr - SR_BASE;
    assign sr_hit = i_sr.we && (sr_ofs[WORD_W-1:IDX_W] == '0);
    assign sr_idx = i_sr.addr[IDX_W-1:0];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < PAGE_ENTRIES; i++) begin
                page_table[i] <= '0;
            end
        end else if (sr_hit) begin
            page_table[sr_idx] <= i_sr.data[PPAGE_W-1:0];
        end
    end

    assign vpage = i_vaddr[VADDR_W-1:PAGE_OFS_W];

    always_comb begin
        if (i_page_en) begin
            o_paddr = {page_table[vpage], i_vaddr[PAGE_OFS_W-1:0]};
        end else begin
            // identity map when paging is off
            o_paddr = paddr_t'(i_vaddr);
        end
    end

endmodule

`default_nettype wire

// ==== logic/instr_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_cache
    import mem_pkg::*;
#(
    parameter int CACHE_LINES = 16
) (
    input wire i_clk,
    input wire i_rst,

    input wire i_fetch_req,
    input wire paddr_t i_fetch_paddr,
    output word_t o_fetch_data,
    output logic o_fetch_ack,
    output logic o_fetch_err,

    input wire i_flush,

    output wb_req_t o_wb,
    input wire wb_rsp_t i_wb
);

    localparam int OFS_W = $clog2(LINE_WORDS);
    localparam int IDX_W = $clog2(CACHE_LINES);
    localparam int TAG_W = PADDR_W - IDX_W - OFS_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_FILL,
        S_RESPOND
    } state_t;

    state_t state;

    paddr_t req_addr;
    logic [OFS_W-1:0] beat;
    logic fill_flushed;

    logic [CACHE_LINES-1:0] line_valid;
    logic [TAG_W-1:0] tag_mem [CACHE_LINES];
    word_t data_mem [CACHE_LINES*LINE_WORDS];

    logic [OFS_W-1:0] req_ofs;
    logic [IDX_W-1:0] req_idx;
    logic [TAG_W-1:0] req_tag;
    logic hit;
    logic last_beat;

    assign req_ofs = req_addr[OFS_W-1:0];
    assign req_idx = req_addr[OFS_W +: IDX_W];
    assign req_tag = req_addr[OFS_W+IDX_W +: TAG_W];
    assign hit = line_valid[req_idx] && (tag_mem[req_idx] == req_tag);
    assign last_beat = beat == OFS_W'(LINE_WORDS - 1);

    // fill addresses walk up from the line base
    always_comb begin
        o_wb = '0;
        o_wb.cyc = state == S_FILL;
        o_wb.stb = state == S_FILL;
        o_wb.burst8 = state == S_FILL;
        o_wb.sel = '1;
        o_wb.adr = {req_addr[PADDR_W-1:OFS_W], beat};
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= S_IDLE;
            line_valid <= '0;
            beat <= '0;
            fill_flushed <= 1'b0;
            o_fetch_ack <= 1'b0;
            o_fetch_err <= 1'b0;
        end else begin
            o_fetch_ack <= 1'b0;
            o_fetch_err <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_fetch_req) begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (hit) begin
                        o_fetch_ack <= 1'b1;
                        state <= S_RESPOND;
                    end else begin
                        // line stays invalid until the whole burst lands
                        line_valid[req_idx] <= 1'b0;
                        beat <= '0;
                        fill_flushed <= 1'b0;
                        state <= S_FILL;
                    end
                end
                S_FILL: begin
                    if (i_wb.err) begin
                        o_fetch_err <= 1'b1;
                        state <= S_RESPOND;
                    end else if (i_wb.ack) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            line_valid[req_idx] <= !fill_flushed && !i_flush;
                            o_fetch_ack <= 1'b1;
                            state <= S_RESPOND;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
            if (state == S_FILL && i_flush) begin
                fill_flushed <= 1'b1;
            end
            if (i_flush) begin
                line_valid <= '0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == S_IDLE && i_fetch_req) begin
            req_addr <= i_fetch_paddr;
        end
        if (state == S_LOOKUP) begin
            if (hit) begin
                o_fetch_data <= data_mem[{req_idx, req_ofs}];
            end else begin
                tag_mem[req_idx] <= req_tag;
            end
        end
        if (state == S_FILL && i_wb.ack && !i_wb.err) begin
            data_mem[{req_idx, beat}] <= i_wb.dat;
            // forward the requested word as it goes by
            if (beat == req_ofs) begin
                o_fetch_data <= i_wb.dat;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/data_bus_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_bus_port
    import mem_pkg::*;
(
    input wire i_clk,
    input wire i_rst,

    input wire i_data_req,
    input wire i_data_we,
    input wire paddr_t i_data_paddr,
    input wire word_t i_data_wdata,
    input wire sel_t i_data_sel,
    output word_t o_data_rdata,
    output logic o_data_ack,
    output logic o_data_exception,

    output wb_req_t o_wb,
    input wire wb_rsp_t i_wb
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUS,
        S_DONE
    } state_t;

    state_t state;

    // core holds its request fields stable, so they drive the bus directly
    always_comb begin
        o_wb = '0;
        o_wb.cyc = state == S_BUS;
        o_wb.stb = state == S_BUS;
        o_wb.we = i_data_we;
        o_wb.adr = i_data_paddr;
        o_wb.dat = i_data_wdata;
        o_wb.sel = i_data_sel;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= S_IDLE;
            o_data_ack <= 1'b0;
            o_data_exception <= 1'b0;
        end else begin
            o_data_ack <= 1'b0;
            o_data_exception <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_data_req) begin
                        state <= S_BUS;
                    end
                end
                S_BUS: begin
                    if (i_wb.err) begin
                        o_data_exception <= 1'b1;
                        state <= S_DONE;
                    end else if (i_wb.ack) begin
                        o_data_ack <= 1'b1;
                        state <= S_DONE;
                    end
                end
                default: begin
                    // one response per request
                    if (!i_data_req) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == S_BUS && i_wb.ack) begin
            o_data_rdata <= i_wb.dat;
        end
    end

endmodule

`default_nettype wire

// ==== logic/wb_priority_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_priority_arbiter
    import mem_pkg::*;
(
    input wire i_clk,
    input wire i_rst,

    input wire wb_req_t i_data_wb,
    input wire wb_req_t i_fetch_wb,
    output wb_rsp_t o_data_wb,
    output wb_rsp_t o_fetch_wb,

    output wb_req_t o_wb,
    input wire wb_rsp_t i_wb
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_DATA,
        OWN_FETCH
    } owner_t;

    owner_t owner;
    logic owner_cyc;
    logic granted;
    wb_req_t bus_req;

    always_comb begin
        case (owner)
            OWN_DATA: owner_cyc = i_data_wb.cyc;
            OWN_FETCH: owner_cyc = i_fetch_wb.cyc;
            default: owner_cyc = 1'b0;
        endcase
    end

    // re-arbitrate with data first once the owner lets go of cyc
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            owner <= OWN_NONE;
        end else if (!owner_cyc) begin
            if (i_data_wb.cyc) begin
                owner <= OWN_DATA;
            end else if (i_fetch_wb.cyc) begin
                owner <= OWN_FETCH;
            end else begin
                owner <= OWN_NONE;
            end
        end
    end

    assign granted = owner != OWN_NONE;
    assign bus_req = (owner == OWN_FETCH) ? i_fetch_wb : i_data_wb;

    always_comb begin
        o_wb = bus_req;
        o_wb.cyc = bus_req.cyc && granted;
        o_wb.stb = bus_req.stb && granted;
        o_wb.burst8 = bus_req.burst8 && granted;
    end

    always_comb begin
        o_data_wb.dat = i_wb.dat;
        o_data_wb.ack = i_wb.ack && owner == OWN_DATA;
        o_data_wb.err = i_wb.err && owner == OWN_DATA;
        o_fetch_wb.dat = i_wb.dat;
        o_fetch_wb.ack = i_wb.ack && owner == OWN_FETCH;
        o_fetch_wb.err = i_wb.err && owner == OWN_FETCH;
    end

endmodule

`default_nettype wire

// ==== logic/mem_upper.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_upper
    import mem_pkg::*;
#(
    parameter int CACHE_LINES = 16,
    parameter word_t INSTR_SR_BASE = 16'h0100,
    parameter word_t DATA_SR_BASE = 16'h0200
) (
    input wire i_clk,
    input wire i_rst,

    input wire i_fetch_req,
    input wire vaddr_t i_fetch_addr,
    output word_t o_fetch_data,
    output logic o_fetch_ack,
    output logic o_fetch_err,
    input wire i_icache_flush,

    input wire i_data_req,
    input wire i_data_we,
    input wire vaddr_t i_data_addr,
    input wire word_t i_data_wdata,
    input wire sel_t i_data_sel,
    output word_t o_data_rdata,
    output logic o_data_ack,
    output logic o_data_exception,

    input wire sr_write_t i_sr,
    input wire i_instr_page_en,
    input wire i_data_page_en,

    output wb_req_t o_wb,
    input wire wb_rsp_t i_wb
);

    paddr_t fetch_paddr;
    paddr_t data_paddr;

    wb_req_t fetch_wb_req;
    wb_req_t data_wb_req;
    wb_rsp_t fetch_wb_rsp;
    wb_rsp_t data_wb_rsp;

    // translation sits in front of the cache, so tags are physical
    page_translator #(
        .SR_BASE(INSTR_SR_BASE)
    ) instr_xlat_i (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_sr(i_sr),
        .i_page_en(i_instr_page_en),
        .i_vaddr(i_fetch_addr),
        .o_paddr(fetch_paddr)
    );

    page_translator #(
        .SR_BASE(DATA_SR_BASE)
    ) data_xlat_i (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_sr(i_sr),
        .i_page_en(i_data_page_en),
        .i_vaddr(i_data_addr),
        .o_paddr(data_paddr)
    );

    instr_cache #(
        .CACHE_LINES(CACHE_LINES)
    ) icache_i (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_fetch_req(i_fetch_req),
        .i_fetch_paddr(fetch_paddr),
        .o_fetch_data(o_fetch_data),
        .o_fetch_ack(o_fetch_ack),
        .o_fetch_err(o_fetch_err),
        .i_flush(i_icache_flush),
        .o_wb(fetch_wb_req),
        .i_wb(fetch_wb_rsp)
    );

    data_bus_port dport_i (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_data_req(i_data_req),
        .i_data_we(i_data_we),
        .i_data_paddr(data_paddr),
        .i_data_wdata(i_data_wdata),
        .i_data_sel(i_data_sel),
        .o_data_rdata(o_data_rdata),
        .o_data_ack(o_data_ack),
        .o_data_exception(o_data_exception),
        .o_wb(data_wb_req),
        .i_wb(data_wb_rsp)
    );

    wb_priority_arbiter wb_arb_i (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_data_wb(data_wb_req),
        .i_fetch_wb(fetch_wb_req),
        .o_data_wb(data_wb_rsp),
        .o_fetch_wb(fetch_wb_rsp),
        .o_wb(o_wb),
        .i_wb(i_wb)
    );

endmodule

`default_nettype wire

// ==== verification/wb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model
    import mem_pkg::*;
(
    input wire i_clk,
    input wire i_rst,

    input wire wb_req_t i_wb,
    output wb_rsp_t o_wb,

    output logic [31:0] o_beats,
    output logic [7:0] o_burst_log
);

    // only written words are kept and the rest reads the address pattern
    paddr_t wr_adr[$];
    word_t wr_dat[$];

    logic cyc_q;

    function automatic int find_slot(input paddr_t adr);
        for (int i = 0; i < wr_adr.size(); i++) begin
            if (wr_adr[i] == adr) begin
                return i;
            end
        end
        return -1;
    endfunction

    always @(posedge i_clk) begin : beat_proc
        int slot;
        word_t cur;
        word_t merged;
        if (i_rst) begin
            o_wb <= '0;
            o_beats <= '0;
            o_burst_log <= '0;
            cyc_q <= 1'b0;
        end else begin
            cyc_q <= i_wb.cyc;
            // one log bit per bus cycle with the newest in bit 0
            if (i_wb.cyc && !cyc_q) begin
                o_burst_log <= {o_burst_log[6:0], i_wb.burst8};
            end
            if (o_wb.ack || o_wb.err) begin
                o_wb.ack <= 1'b0;
                o_wb.err <= 1'b0;
            end else if (i_wb.cyc && i_wb.stb) begin
                o_beats <= o_beats + 1;
                if (i_wb.adr[PADDR_W-1 -: 4] == 4'hF) begin
                    o_wb.err <= 1'b1;
                end else begin
                    slot = find_slot(i_wb.adr);
                    cur = (slot >= 0) ? wr_dat[slot] : (i_wb.adr[15:0] ^ 16'h5A5A);
                    if (i_wb.we) begin
                        merged = cur;
                        if (i_wb.sel[0]) begin
                            merged[7:0] = i_wb.dat[7:0];
                        end
                        if (i_wb.sel[1]) begin
                            merged[15:8] = i_wb.dat[15:8];
                        end
                        if (slot >= 0) begin
                            wr_dat[slot] = merged;
                        end else begin
                            wr_adr.push_back(i_wb.adr);
                            wr_dat.push_back(merged);
                        end
                    end
                    o_wb.dat <= cur;
                    o_wb.ack <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/mem_upper_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_upper_tb
    import mem_pkg::*;
();

    localparam word_t INSTR_BASE = 16'h0100;
    localparam word_t DATA_BASE = 16'h0200;
    localparam int RESET_CYCLES = 5;
    localparam int CYCLES_PER_TEST = 40;

    localparam logic [2:0] OP_FETCH = 3'd0;
    localparam logic [2:0] OP_READ = 3'd1;
    localparam logic [2:0] OP_WRITE = 3'd2;
    localparam logic [2:0] OP_SR = 3'd3;
    localparam logic [2:0] OP_PAGE = 3'd4;
    localparam logic [2:0] OP_FLUSH = 3'd5;
    localparam logic [2:0] OP_BOTH = 3'd6;

    // addr2 is the data address of a combined fetch and read
    typedef struct packed {
        logic [2:0] op;
        vaddr_t addr;
        vaddr_t addr2;
        word_t wdata;
        sel_t sel;
        word_t exp;
        word_t exp2;
        logic exp_err;
        logic [4:0] beats;
    } test_t;

    logic clk = 1'b0;
    logic rst;
    logic fetch_req;
    vaddr_t fetch_addr;
    word_t fetch_data;
    logic fetch_ack;
    logic fetch_err;
    logic icache_flush;
    logic data_req;
    logic data_we;
    vaddr_t data_addr;
    word_t data_wdata;
    sel_t data_sel;
    word_t data_rdata;
    logic data_ack;
    logic data_exception;
    sr_write_t sr;
    logic instr_page_en;
    logic data_page_en;
    wb_req_t bus_req;
    wb_rsp_t bus_rsp;
    logic [31:0] beat_count;
    logic [7:0] burst_log;

    test_t tests[$];
    integer seed = 21795;
    int errors = 0;
    int failed_tests = 0;
    int cycle_count = 0;
    int timeout_limit = 0;

    mem_upper #(
        .CACHE_LINES(16),
        .INSTR_SR_BASE(INSTR_BASE),
        .DATA_SR_BASE(DATA_BASE)
    ) mem_upper_i (
        .i_clk(clk),
        .i_rst(rst),
        .i_fetch_req(fetch_req),
        .i_fetch_addr(fetch_addr),
        .o_fetch_data(fetch_data),
        .o_fetch_ack(fetch_ack),
        .o_fetch_err(fetch_err),
        .i_icache_flush(icache_flush),
        .i_data_req(data_req),
        .i_data_we(data_we),
        .i_data_addr(data_addr),
        .i_data_wdata(data_wdata),
        .i_data_sel(data_sel),
        .o_data_rdata(data_rdata),
        .o_data_ack(data_ack),
        .o_data_exception(data_exception),
        .i_sr(sr),
        .i_instr_page_en(instr_page_en),
        .i_data_page_en(data_page_en),
        .o_wb(bus_req),
        .i_wb(bus_rsp)
    );

    wb_mem_model mem_model_i (
        .i_clk(clk),
        .i_rst(rst),
        .i_wb(bus_req),
        .o_wb(bus_rsp),
        .o_beats(beat_count),
        .o_burst_log(burst_log)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: no response within %0d cycles", timeout_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // unwritten memory reads back as its address pattern
    function automatic word_t model_value(input paddr_t adr);
        return adr[15:0] ^ 16'h5A5A;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t wr, input sel_t sel);
        word_t res;
        res = old;
        if (sel[0]) begin
            res[7:0] = wr[7:0];
        end
        if (sel[1]) begin
            res[15:8] = wr[15:8];
        end
        return res;
    endfunction

    function automatic string op_name(input logic [2:0] op);
        case (op)
            OP_FETCH: return "fetch";
            OP_READ: return "read";
            OP_WRITE: return "write";
            OP_SR: return "sr write";
            OP_PAGE: return "page enable";
            OP_FLUSH: return "flush";
            default: return "fetch+read";
        endcase
    endfunction

    task automatic note_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, sig, got, exp);
        errors++;
    endtask

    task automatic add_entry(input logic [2:0] op, input vaddr_t addr, input vaddr_t addr2,
                             input word_t wdata, input sel_t sel, input word_t exp,
                             input word_t exp2, input logic exp_err, input int beats);
        test_t t;
        t.op = op;
        t.addr = addr;
        t.addr2 = addr2;
        t.wdata = wdata;
        t.sel = sel;
        t.exp = exp;
        t.exp2 = exp2;
        t.exp_err = exp_err;
        t.beats = 5'(beats);
        tests.push_back(t);
    endtask

    task automatic build_table();
        sel_t sel_order[4] = '{2'b11, 2'b01, 2'b10, 2'b00};
        vaddr_t fa;
        vaddr_t da;
        vaddr_t va;
        vaddr_t fb;
        ppage_t pi;
        ppage_t pd;
        ppage_t pe;
        word_t w;
        word_t cur;
        // line fill, then a hit in the same line
        fa = {4'h1, 12'($random(seed))};
        add_entry(OP_FETCH, fa, 0, 0, 0, model_value(paddr_t'(fa)), 0, 0, 8);
        va = {fa[15:3], ~fa[2:0]};
        add_entry(OP_FETCH, va, 0, 0, 0, model_value(paddr_t'(va)), 0, 0, 0);
        // byte lanes
        da = {4'h2, 12'($random(seed))};
        cur = model_value(paddr_t'(da));
        for (int i = 0; i < 4; i++) begin
            w = 16'($random(seed));
            cur = merge_bytes(cur, w, sel_order[i]);
            add_entry(OP_WRITE, da, 0, w, sel_order[i], 0, 0, 0, 1);
            add_entry(OP_READ, da, 0, 0, 2'b11, cur, 0, 0, 1);
        end
        // writes outside both page table windows must not land
        // only the low nibble of a page reaches the model pattern
        pi = {4'h3, 4'($random(seed)), 4'hC};
        pd = {4'h4, 4'($random(seed)), 4'hD};
        add_entry(OP_SR, INSTR_BASE + 16'h3, 0, 16'(pi), 0, 0, 0, 0, 0);
        add_entry(OP_SR, DATA_BASE + 16'h5, 0, 16'(pd), 0, 0, 0, 0, 0);
        add_entry(OP_SR, 16'h0013, 0, 16'h07C1, 0, 0, 0, 0, 0);
        add_entry(OP_SR, 16'h0305, 0, 16'h07C2, 0, 0, 0, 0, 0);
        add_entry(OP_PAGE, 0, 0, 16'h0003, 0, 0, 0, 0, 0);
        va = {4'h3, 12'($random(seed))};
        add_entry(OP_FETCH, va, 0, 0, 0, model_value({pi, va[11:0]}), 0, 0, 8);
        va = {4'h5, 12'($random(seed))};
        add_entry(OP_READ, va, 0, 0, 2'b11, model_value({pd, va[11:0]}), 0, 0, 1);
        add_entry(OP_PAGE, 0, 0, 16'h0000, 0, 0, 0, 0, 0);
        // stale line until flushed
        fb = {4'h6, 12'($random(seed))};
        w = 16'($random(seed));
        add_entry(OP_FETCH, fb, 0, 0, 0, model_value(paddr_t'(fb)), 0, 0, 8);
        add_entry(OP_WRITE, fb, 0, w, 2'b11, 0, 0, 0, 1);
        add_entry(OP_FETCH, fb, 0, 0, 0, model_value(paddr_t'(fb)), 0, 0, 0);
        add_entry(OP_FLUSH, 0, 0, 0, 0, 0, 0, 0, 0);
        add_entry(OP_FETCH, fb, 0, 0, 0, w, 0, 0, 8);
        // error region through page 7 of both tables
        pe = {4'hF, 8'($random(seed))};
        add_entry(OP_SR, INSTR_BASE + 16'h7, 0, 16'(pe), 0, 0, 0, 0, 0);
        add_entry(OP_SR, DATA_BASE + 16'h7, 0, 16'(pe), 0, 0, 0, 0, 0);
        add_entry(OP_PAGE, 0, 0, 16'h0003, 0, 0, 0, 0, 0);
        va = {4'h7, 12'($random(seed))};
        add_entry(OP_READ, va, 0, 0, 2'b11, 0, 0, 1, 1);
        add_entry(OP_WRITE, va, 0, 16'h1234, 2'b11, 0, 0, 1, 1);
        add_entry(OP_FETCH, va, 0, 0, 0, 0, 0, 1, 1);
        add_entry(OP_FETCH, va, 0, 0, 0, 0, 0, 1, 1);
        add_entry(OP_PAGE, 0, 0, 16'h0000, 0, 0, 0, 0, 0);
        // fetch miss and data read raised together
        fa = {4'h8, 12'($random(seed))};
        da = {4'h9, 12'($random(seed))};
        add_entry(OP_BOTH, fa, da, 0, 2'b11, model_value(paddr_t'(fa)),
                  model_value(paddr_t'(da)), 0, 9);
    endtask

    task automatic apply_entry(input test_t t, input int idx);
        int err_before;
        int beats_before;
        int beats_got;
        logic fetch_done;
        logic data_done;
        logic fetch_err_got;
        logic data_exc_got;
        word_t fetch_got;
        word_t data_got;
        err_before = errors;
        beats_before = beat_count;
        fetch_done = !(t.op == OP_FETCH || t.op == OP_BOTH);
        data_done = !(t.op == OP_READ || t.op == OP_WRITE || t.op == OP_BOTH);
        if (!fetch_done) begin
            fetch_req = 1'b1;
            fetch_addr = t.addr;
        end
        if (!data_done) begin
            data_req = 1'b1;
            data_we = t.op == OP_WRITE;
            data_addr = (t.op == OP_BOTH) ? t.addr2 : t.addr;
            data_wdata = t.wdata;
            data_sel = t.sel;
        end
        if (t.op == OP_SR) begin
            sr = {1'b1, t.addr, t.wdata};
        end
        if (t.op == OP_PAGE) begin
            instr_page_en = t.wdata[0];
            data_page_en = t.wdata[1];
        end
        icache_flush = t.op == OP_FLUSH;
        @(negedge clk);
        sr.we = 1'b0;
        icache_flush = 1'b0;
        while (!(fetch_done && data_done)) begin
            if (!fetch_done && (fetch_ack || fetch_err)) begin
                fetch_done = 1'b1;
                fetch_err_got = fetch_err;
                fetch_got = fetch_data;
                fetch_req = 1'b0;
            end
            if (!data_done && (data_ack || data_exception)) begin
                data_done = 1'b1;
                data_exc_got = data_exception;
                data_got = data_rdata;
                data_req = 1'b0;
            end
            if (!(fetch_done && data_done)) begin
                @(negedge clk);
            end
        end
        beats_got = int'(beat_count) - beats_before;
        if (t.op == OP_FETCH || t.op == OP_BOTH) begin
            assert (fetch_err_got == t.exp_err)
            else note_mismatch("o_fetch_err", fetch_err_got, t.exp_err);
            if (!t.exp_err) begin
                assert (fetch_got == t.exp)
                else note_mismatch("o_fetch_data", fetch_got, t.exp);
            end
        end
        if (t.op == OP_READ || t.op == OP_WRITE || t.op == OP_BOTH) begin
            assert (data_exc_got == t.exp_err)
            else note_mismatch("o_data_exception", data_exc_got, t.exp_err);
        end
        if (t.op == OP_READ && !t.exp_err) begin
            assert (data_got == t.exp)
            else note_mismatch("o_data_rdata", data_got, t.exp);
        end
        if (t.op == OP_BOTH) begin
            assert (data_got == t.exp2)
            else note_mismatch("o_data_rdata", data_got, t.exp2);
            // data cycle first without burst8, then the burst
            assert (burst_log[1:0] == 2'b01)
            else note_mismatch("burst8 log", burst_log[1:0], 2'b01);
        end
        assert (beats_got == t.beats)
        else note_mismatch("bus beats", beats_got, t.beats);
        if (t.beats != 0 && t.op != OP_BOTH) begin
            assert (burst_log[0] == (t.op == OP_FETCH))
            else note_mismatch("burst8", burst_log[0], t.op == OP_FETCH);
        end
        if (errors != err_before) begin
            failed_tests++;
        end
        $display("test %0d %s at 0x%h: %s", idx, op_name(t.op), t.addr,
                 (errors == err_before) ? "ok" : "failed");
        @(negedge clk);
    endtask

    initial begin
        rst = 1'b1;
        fetch_req = 1'b0;
        fetch_addr = '0;
        icache_flush = 1'b0;
        data_req = 1'b0;
        data_we = 1'b0;
        data_addr = '0;
        data_wdata = '0;
        data_sel = '0;
        sr = '0;
        instr_page_en = 1'b0;
        data_page_en = 1'b0;
        build_table();
        timeout_limit = RESET_CYCLES + tests.size() * CYCLES_PER_TEST;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        assert (!fetch_ack && !fetch_err && !data_ack && !data_exception
                && !bus_req.cyc && !bus_req.stb && !bus_req.burst8)
        else begin
            $display("outputs were not idle at the end of reset");
            errors++;
        end
        rst = 1'b0;
        @(negedge clk);
        foreach (tests[i]) begin
            apply_entry(tests[i], i);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d check errors", tests.size(),
                 tests.size() - failed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/mem_pkg.sv
logic/page_translator.sv
logic/instr_cache.sv
logic/data_bus_port.sv
logic/wb_priority_arbiter.sv
logic/mem_upper.sv
verification/wb_mem_model.sv
verification/mem_upper_tb.sv
